// ==== cpu_assertions.sv ====
// bound into cpu_top and watches its internal grants; fire_count counts the failed assertions
`timescale 1ns/1ps
`default_nettype none

module cpu_assertions (
    input logic       clk_i,
    input logic       rst_i,
    input logic       load_gnt_i,
    input logic       data_gnt_i,
    input logic       fetch_gnt_i,
    input logic       wb_valid_i,
    input logic [4:0] wb_rd_i,
    input logic       st_valid_i
);

    int fire_count = 0;

    a_one_grant: assert property (@(posedge clk_i) disable iff (rst_i)
        $onehot0({load_gnt_i, data_gnt_i, fetch_gnt_i}))
    else
    begin
        $error("more than one memory grant in the same cycle");
        fire_count++;
    end

    // x0 writes are dropped before the trace
    a_no_x0_write: assert property (@(posedge clk_i) disable iff (rst_i)
        !(wb_valid_i && wb_rd_i == 5'd0))
    else
    begin
        $error("write trace reports register x0");
        fire_count++;
    end

    a_one_trace: assert property (@(posedge clk_i) disable iff (rst_i)
        !(wb_valid_i && st_valid_i))
    else
    begin
        $error("write trace and store trace valid together");
        fire_count++;
    end

    a_quiet_after_reset: assert property (@(posedge clk_i)
        rst_i |=> (!wb_valid_i && !st_valid_i))
    else
    begin
        $error("trace valid high in the cycle after reset");
        fire_count++;
    end

endmodule

bind cpu_top cpu_assertions u_props (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .load_gnt_i (load_bus.gnt),
    .data_gnt_i (data_bus.gnt),
    .fetch_gnt_i(fetch_bus.gnt),
    .wb_valid_i (wb_valid_o),
    .wb_rd_i    (wb_rd_o),
    .st_valid_i (st_valid_o)
);

`default_nettype wire

// ==== cpu_golden.hex ====
# P word: program word for the next address, starting at 0
# W rd data: expected register write; S addr data: expected store; all values hex
P 00500093  # 00 addi x1, x0, 5
P ff408113  # 04 addi x2, x1, -12
P 002081b3  # 08 add  x3, x1, x2
P 40208233  # 0c sub  x4, x1, x2
P 0041f2b3  # 10 and  x5, x3, x4
P 00116333  # 14 or   x6, x2, x1
P 001123b3  # 18 slt  x7, x2, x1
P 10602023  # 1c sw   x6, 0x100(x0)
P 10002403  # 20 lw   x8, 0x100(x0)
P 00208463  # 24 beq  x1, x2, +8 not taken
P 00520663  # 28 beq  x4, x5, +12 taken
P 00100493  # 2c addi x9, x0, 1 skipped
P 00200493  # 30 addi x9, x0, 2 skipped
P 00c0056f  # 34 jal  x10, +12
P 00300593  # 38 addi x11, x0, 3 skipped
P 00400593  # 3c addi x11, x0, 4 skipped
P 01450667  # 40 jalr x12, 0x14(x10)
P 00500593  # 44 addi x11, x0, 5 skipped
P 00600593  # 48 addi x11, x0, 6 skipped
P 00160713  # 4c addi x14, x12, 1
P 0000006f  # 50 jal  x0, 0 self-loop
P 00000000  # 54 bubble
P 00000000  # 58 bubble
W 01 00000005
W 02 fffffff9
W 03 fffffffe
W 04 0000000c
W 05 0000000c
W 06 fffffffd
W 07 00000001
S 00000100 fffffffd
W 08 fffffffd
W 0a 00000038
W 0c 00000044
W 0e 00000045

// ==== cpu_top.sv ====
// loader writes take priority over the core; fetch stalls while load_we_i is high
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  logic                       load_we_i,
    input  logic [riscv_pkg::XLEN-1:0] load_addr_i,
    input  logic [riscv_pkg::XLEN-1:0] load_data_i,
    output logic                       wb_valid_o,
    output logic [4:0]                 wb_rd_o,
    output logic [riscv_pkg::XLEN-1:0] wb_data_o,
    output logic                       st_valid_o,
    output logic [riscv_pkg::XLEN-1:0] st_addr_o,
    output logic [riscv_pkg::XLEN-1:0] st_data_o
);
    import riscv_pkg::*;

    mem_port_if load_bus ();
    mem_port_if data_bus ();
    mem_port_if fetch_bus ();

    logic [XLEN-1:0] instr_d;
    logic [XLEN-1:0] pc_d;
    logic [XLEN-1:0] pc_plus4_d;
    logic [4:0]      rs1_d;
    logic [4:0]      rs2_d;
    logic [4:0]      rd_d;
    logic [XLEN-1:0] imm_d;
    logic [XLEN-1:0] rd1_d;
    logic [XLEN-1:0] rd2_d;
    logic            reg_write_d;
    result_src_e     result_src_d;
    logic            mem_write_d;
    logic            mem_read_d;
    jump_e           jump_d;
    logic            branch_d;
    alu_op_e         alu_ctrl_d;
    logic            alu_src_d;

    logic [XLEN-1:0] rd1_e;
    logic [XLEN-1:0] rd2_e;
    logic [XLEN-1:0] pc_e;
    logic [4:0]      rd_e;
    logic [XLEN-1:0] imm_e;
    logic [XLEN-1:0] pc_plus4_e;
    logic            reg_write_e;
    result_src_e     res_src_e;
    logic            mem_write_e;
    logic            mem_read_e;
    jump_e           jmp_e;
    logic            branch_e;
    alu_op_e         alu_ctrl_e;
    logic            alu_src_e;

    logic            flush;
    logic [XLEN-1:0] target;
    logic            rf_we;
    logic [4:0]      rf_wa;
    logic [XLEN-1:0] rf_wd;

    // external loader is write-only
    assign load_bus.req   = load_we_i;
    assign load_bus.we    = load_we_i;
    assign load_bus.addr  = load_addr_i;
    assign load_bus.wdata = load_data_i;

    assign pc_plus4_d = pc_d + XLEN'(4);      // link value for jal/jalr

    fetch_stage u_fetch (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .mem     (fetch_bus.requester),
        .flush_i (flush),
        .target_i(target),
        .instr_o (instr_d),
        .pc_o    (pc_d)
    );

    decoder u_dec (
        .instr_i     (instr_d),
        .rs1_o       (rs1_d),
        .rs2_o       (rs2_d),
        .rd_o        (rd_d),
        .imm_ext_o   (imm_d),
        .reg_write_o (reg_write_d),
        .result_src_o(result_src_d),
        .mem_write_o (mem_write_d),
        .mem_read_o  (mem_read_d),
        .jump_o      (jump_d),
        .branch_o    (branch_d),
        .alu_ctrl_o  (alu_ctrl_d),
        .alu_src_o   (alu_src_d)
    );

    reg_file u_rf (
        .clk_i(clk_i),
        .rs1_i(rs1_d),
        .rs2_i(rs2_d),
        .rd1_o(rd1_d),
        .rd2_o(rd2_d),
        .we_i (rf_we),
        .wa_i (rf_wa),
        .wd_i (rf_wd)
    );

    pipe_reg2 u_pr2 (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .flush_i       (flush),
        .rd1_d_i       (rd1_d),
        .rd2_d_i       (rd2_d),
        .pc_d_i        (pc_d),
        .rd_d_i        (rd_d),
        .imm_ext_d_i   (imm_d),
        .pc_plus4_d_i  (pc_plus4_d),
        .reg_write_d_i (reg_write_d),
        .result_src_d_i(result_src_d),
        .mem_write_d_i (mem_write_d),
        .mem_read_d_i  (mem_read_d),
        .jump_d_i      (jump_d),
        .branch_d_i    (branch_d),
        .alu_ctrl_d_i  (alu_ctrl_d),
        .alu_src_d_i   (alu_src_d),
        .rd1_e_o       (rd1_e),
        .rd2_e_o       (rd2_e),
        .pc_e_o        (pc_e),
        .rd_e_o        (rd_e),
        .imm_ext_e_o   (imm_e),
        .pc_plus4_e_o  (pc_plus4_e),
        .reg_write_e_o (reg_write_e),
        .result_src_e_o(res_src_e),
        .mem_write_e_o (mem_write_e),
        .mem_read_e_o  (mem_read_e),
        .jump_e_o      (jmp_e),
        .branch_e_o    (branch_e),
        .alu_ctrl_e_o  (alu_ctrl_e),
        .alu_src_e_o   (alu_src_e)
    );

    execute_stage u_exe (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .mem           (data_bus.requester),
        .rd1_e_i       (rd1_e),
        .rd2_e_i       (rd2_e),
        .pc_e_i        (pc_e),
        .rd_e_i        (rd_e),
        .imm_ext_e_i   (imm_e),
        .pc_plus4_e_i  (pc_plus4_e),
        .reg_write_e_i (reg_write_e),
        .result_src_e_i(res_src_e),
        .mem_write_e_i (mem_write_e),
        .mem_read_e_i  (mem_read_e),
        .jump_e_i      (jmp_e),
        .branch_e_i    (branch_e),
        .alu_ctrl_e_i  (alu_ctrl_e),
        .alu_src_e_i   (alu_src_e),
        .flush_o       (flush),
        .target_o      (target),
        .wb_we_o       (rf_we),
        .wb_rd_o       (rf_wa),
        .wb_data_o     (rf_wd),
        .tr_wb_valid_o (wb_valid_o),
        .tr_wb_rd_o    (wb_rd_o),
        .tr_wb_data_o  (wb_data_o),
        .tr_st_valid_o (st_valid_o),
        .tr_st_addr_o  (st_addr_o),
        .tr_st_data_o  (st_data_o)
    );

    shared_mem u_mem (
        .clk_i     (clk_i),
        .load_port (load_bus.memory),
        .data_port (data_bus.memory),
        .fetch_port(fetch_bus.memory)
    );

endmodule

`default_nettype wire

// ==== decoder.sv ====
// decodes ADD SUB AND OR SLT ADDI LW SW BEQ JAL JALR; every other word is a bubble
`timescale 1ns/1ps
`default_nettype none

module decoder (
    input  logic [riscv_pkg::XLEN-1:0] instr_i,
    output logic [4:0]                 rs1_o,
    output logic [4:0]                 rs2_o,
    output logic [4:0]                 rd_o,
    output logic [riscv_pkg::XLEN-1:0] imm_ext_o,
    output logic                       reg_write_o,
    output riscv_pkg::result_src_e     result_src_o,
    output logic                       mem_write_o,
    output logic                       mem_read_o,
    output riscv_pkg::jump_e           jump_o,
    output logic                       branch_o,
    output riscv_pkg::alu_op_e         alu_ctrl_o,
    output logic                       alu_src_o
);
    import riscv_pkg::*;

    opcode_e         opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_j;

    assign opcode = opcode_e'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];
    assign rs1_o  = instr_i[19:15];
    assign rs2_o  = instr_i[24:20];
    assign rd_o   = instr_i[11:7];

    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

    always_comb
    begin
        reg_write_o  = 1'b0;
        result_src_o = RES_ALU;
        mem_write_o  = 1'b0;
        mem_read_o   = 1'b0;
        jump_o       = JMP_NONE;
        branch_o     = 1'b0;
        alu_ctrl_o   = ALU_ADD;
        alu_src_o    = 1'b0;
        imm_ext_o    = imm_i;
        case (opcode)
            OP:
            begin
                reg_write_o = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: alu_ctrl_o = ALU_ADD;
                    10'b0100000_000: alu_ctrl_o = ALU_SUB;
                    10'b0000000_010: alu_ctrl_o = ALU_SLT;
                    10'b0000000_110: alu_ctrl_o = ALU_OR;
                    10'b0000000_111: alu_ctrl_o = ALU_AND;
                    default:         reg_write_o = 1'b0;    // other R-type ops
                endcase
            end
            OP_IMM:
            begin
                reg_write_o = (funct3 == 3'b000);           // addi only
                alu_src_o   = 1'b1;
            end
            LOAD:
            begin
                reg_write_o  = (funct3 == 3'b010);          // lw only
                mem_read_o   = (funct3 == 3'b010);
                result_src_o = RES_MEM;
                alu_src_o    = 1'b1;
            end
            STORE:
            begin
                mem_write_o = (funct3 == 3'b010);           // sw only
                alu_src_o   = 1'b1;
                imm_ext_o   = imm_s;
            end
            BRANCH:
            begin
                branch_o   = (funct3 == 3'b000);            // beq only
                alu_ctrl_o = ALU_SUB;                       // equal when result is zero
                imm_ext_o  = imm_b;
            end
            JAL:
            begin
                reg_write_o  = 1'b1;
                jump_o       = JMP_JAL;
                result_src_o = RES_PC4;
                imm_ext_o    = imm_j;
            end
            JALR:
            begin
                if (funct3 == 3'b000)
                begin
                    reg_write_o  = 1'b1;
                    jump_o       = JMP_JALR;
                    result_src_o = RES_PC4;
                    alu_src_o    = 1'b1;                    // target is rs1 + imm
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== execute_stage.sv ====
// execute also does memory access and writeback; writes to x0 are dropped and never traced
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic                       clk_i,
    input  logic                       rst_i,
    mem_port_if.requester              mem,
    input  logic [riscv_pkg::XLEN-1:0] rd1_e_i,
    input  logic [riscv_pkg::XLEN-1:0] rd2_e_i,
    input  logic [riscv_pkg::XLEN-1:0] pc_e_i,
    input  logic [4:0]                 rd_e_i,
    input  logic [riscv_pkg::XLEN-1:0] imm_ext_e_i,
    input  logic [riscv_pkg::XLEN-1:0] pc_plus4_e_i,
    input  logic                       reg_write_e_i,
    input  riscv_pkg::result_src_e     result_src_e_i,
    input  logic                       mem_write_e_i,
    input  logic                       mem_read_e_i,
    input  riscv_pkg::jump_e           jump_e_i,
    input  logic                       branch_e_i,
    input  riscv_pkg::alu_op_e         alu_ctrl_e_i,
    input  logic                       alu_src_e_i,
    output logic                       flush_o,
    output logic [riscv_pkg::XLEN-1:0] target_o,
    output logic                       wb_we_o,
    output logic [4:0]                 wb_rd_o,
    output logic [riscv_pkg::XLEN-1:0] wb_data_o,
    output logic                       tr_wb_valid_o,
    output logic [4:0]                 tr_wb_rd_o,
    output logic [riscv_pkg::XLEN-1:0] tr_wb_data_o,
    output logic                       tr_st_valid_o,
    output logic [riscv_pkg::XLEN-1:0] tr_st_addr_o,
    output logic [riscv_pkg::XLEN-1:0] tr_st_data_o
);
    import riscv_pkg::*;

    logic [XLEN-1:0] src_b;
    logic [XLEN-1:0] alu_res;

    assign src_b = alu_src_e_i ? imm_ext_e_i : rd2_e_i;

    always_comb
    begin
        case (alu_ctrl_e_i)
            ALU_ADD: alu_res = rd1_e_i + src_b;
            ALU_SUB: alu_res = rd1_e_i - src_b;
            ALU_AND: alu_res = rd1_e_i & src_b;
            ALU_OR:  alu_res = rd1_e_i | src_b;
            ALU_SLT: alu_res = {{(XLEN-1){1'b0}}, $signed(rd1_e_i) < $signed(src_b)};
            default: alu_res = '0;
        endcase
    end

    // beq compares through the subtractor, jumps are always taken
    assign flush_o  = (branch_e_i && alu_res == '0) || (jump_e_i != JMP_NONE);
    assign target_o = (jump_e_i == JMP_JALR) ? {alu_res[XLEN-1:1], 1'b0}
                                             : pc_e_i + imm_ext_e_i;

    assign mem.req   = mem_read_e_i | mem_write_e_i;
    assign mem.we    = mem_write_e_i;
    assign mem.addr  = alu_res;
    assign mem.wdata = rd2_e_i;

    always_comb
    begin
        case (result_src_e_i)
            RES_MEM: wb_data_o = mem.rdata;
            RES_PC4: wb_data_o = pc_plus4_e_i;
            default: wb_data_o = alu_res;
        endcase
    end

    assign wb_we_o = reg_write_e_i && (rd_e_i != 5'd0);
    assign wb_rd_o = rd_e_i;

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            tr_wb_valid_o <= 1'b0;
            tr_st_valid_o <= 1'b0;
        end
        else
        begin
            tr_wb_valid_o <= wb_we_o;
            tr_st_valid_o <= mem_write_e_i && mem.gnt;   // only stores that landed
        end
    end

    always_ff @(posedge clk_i)
    begin
        tr_wb_rd_o   <= rd_e_i;
        tr_wb_data_o <= wb_data_o;
        tr_st_addr_o <= alu_res;
        tr_st_data_o <= rd2_e_i;
    end

endmodule

`default_nettype wire

// ==== fetch_stage.sv ====
// fetch requests every cycle; a missing grant or a flush puts a zero word (bubble) into decode
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
    input  logic                       clk_i,
    input  logic                       rst_i,
    mem_port_if.requester              mem,
    input  logic                       flush_i,
    input  logic [riscv_pkg::XLEN-1:0] target_i,
    output logic [riscv_pkg::XLEN-1:0] instr_o,
    output logic [riscv_pkg::XLEN-1:0] pc_o
);
    import riscv_pkg::*;

    logic [XLEN-1:0] pc_q;

    assign mem.req   = 1'b1;         // never idle
    assign mem.we    = 1'b0;
    assign mem.addr  = pc_q;
    assign mem.wdata = '0;

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            pc_q    <= RESET_PC;
            instr_o <= '0;
        end
        else if (flush_i)
        begin
            pc_q    <= target_i;     // redirect from execute
            instr_o <= '0;           // drop the wrong-path word
        end
        else if (mem.gnt)
        begin
            pc_q    <= pc_q + XLEN'(4);
            instr_o <= mem.rdata;
        end
        else
            instr_o <= '0;           // lost arbitration, pc holds
    end

    always_ff @(posedge clk_i)
    begin
        pc_o <= pc_q;                // only meaningful with a valid word
    end

endmodule

`default_nettype wire

// ==== mem_port_if.sv ====
// one requester on the shared memory; gnt and rdata are valid in the cycle of req
`timescale 1ns/1ps
`default_nettype none

interface mem_port_if;
    import riscv_pkg::*;

    logic            req;
    logic            we;
    logic [XLEN-1:0] addr;           // byte address
    logic [XLEN-1:0] wdata;
    logic            gnt;
    logic [XLEN-1:0] rdata;

    modport requester (output req, we, addr, wdata, input gnt, rdata);
    modport memory    (input req, we, addr, wdata, output gnt, rdata);

endinterface

`default_nettype wire

// ==== pipe_reg2.sv ====
// decode to execute register; reset or flush clears only the controls that have side effects
`timescale 1ns/1ps
`default_nettype none

module pipe_reg2 (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  logic                       flush_i,

    input  logic [riscv_pkg::XLEN-1:0] rd1_d_i,
    input  logic [riscv_pkg::XLEN-1:0] rd2_d_i,
    input  logic [riscv_pkg::XLEN-1:0] pc_d_i,
    input  logic [4:0]                 rd_d_i,
    input  logic [riscv_pkg::XLEN-1:0] imm_ext_d_i,
    input  logic [riscv_pkg::XLEN-1:0] pc_plus4_d_i,
    input  logic                       reg_write_d_i,
    input  riscv_pkg::result_src_e     result_src_d_i,
    input  logic                       mem_write_d_i,
    input  logic                       mem_read_d_i,
    input  riscv_pkg::jump_e           jump_d_i,
    input  logic                       branch_d_i,
    input  riscv_pkg::alu_op_e         alu_ctrl_d_i,
    input  logic                       alu_src_d_i,

    output logic [riscv_pkg::XLEN-1:0] rd1_e_o,
    output logic [riscv_pkg::XLEN-1:0] rd2_e_o,
    output logic [riscv_pkg::XLEN-1:0] pc_e_o,
    output logic [4:0]                 rd_e_o,
    output logic [riscv_pkg::XLEN-1:0] imm_ext_e_o,
    output logic [riscv_pkg::XLEN-1:0] pc_plus4_e_o,
    output logic                       reg_write_e_o,
    output riscv_pkg::result_src_e     result_src_e_o,
    output logic                       mem_write_e_o,
    output logic                       mem_read_e_o,
    output riscv_pkg::jump_e           jump_e_o,
    output logic                       branch_e_o,
    output riscv_pkg::alu_op_e         alu_ctrl_e_o,
    output logic                       alu_src_e_o
);
    import riscv_pkg::*;

    always_ff @(posedge clk_i)
    begin
        if (rst_i || flush_i)
        begin
            reg_write_e_o <= 1'b0;        // stage becomes a bubble
            mem_write_e_o <= 1'b0;
            mem_read_e_o  <= 1'b0;
            jump_e_o      <= JMP_NONE;
            branch_e_o    <= 1'b0;
        end
        else
        begin
            reg_write_e_o <= reg_write_d_i;
            mem_write_e_o <= mem_write_d_i;
            mem_read_e_o  <= mem_read_d_i;
            jump_e_o      <= jump_d_i;
            branch_e_o    <= branch_d_i;
        end
    end

    always_ff @(posedge clk_i)
    begin
        rd1_e_o        <= rd1_d_i;
        rd2_e_o        <= rd2_d_i;
        pc_e_o         <= pc_d_i;
        rd_e_o         <= rd_d_i;
        imm_ext_e_o    <= imm_ext_d_i;
        pc_plus4_e_o   <= pc_plus4_d_i;
        result_src_e_o <= result_src_d_i;
        alu_ctrl_e_o   <= alu_ctrl_d_i;
        alu_src_e_o    <= alu_src_d_i;
    end

endmodule

`default_nettype wire

// ==== reg_file.sv ====
// x0 is not stored; a read of the register being written returns the new value
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                       clk_i,
    input  logic [4:0]                 rs1_i,
    input  logic [4:0]                 rs2_i,
    output logic [riscv_pkg::XLEN-1:0] rd1_o,
    output logic [riscv_pkg::XLEN-1:0] rd2_o,
    input  logic                       we_i,
    input  logic [4:0]                 wa_i,
    input  logic [riscv_pkg::XLEN-1:0] wd_i
);
    import riscv_pkg::*;

    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge clk_i)
    begin
        if (we_i && wa_i != 5'd0)
            regs[wa_i] <= wd_i;
    end

    // write-first bypass, replaces a forwarding unit
    assign rd1_o = (rs1_i == 5'd0) ? '0 :
                   (we_i && wa_i == rs1_i) ? wd_i : regs[rs1_i];
    assign rd2_o = (rs2_i == 5'd0) ? '0 :
                   (we_i && wa_i == rs2_i) ? wd_i : regs[rs2_i];

endmodule

`default_nettype wire

// ==== riscv_pkg.sv ====
// RV32I subset only; memory addresses are byte addresses with word-aligned access
`default_nettype none

package riscv_pkg;

    localparam int XLEN      = 32;                   // data and address width
    localparam int MEM_WORDS = 256;                  // shared memory depth
    localparam int MEM_AW    = $clog2(MEM_WORDS);    // word index, taken from addr[9:2]
    localparam logic [XLEN-1:0] RESET_PC = '0;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT                                      // signed compare
    } alu_op_e;

    typedef enum logic [1:0] {
        RES_ALU,
        RES_MEM,
        RES_PC4                                      // link value of jal/jalr
    } result_src_e;

    typedef enum logic [1:0] {
        JMP_NONE,
        JMP_JAL,
        JMP_JALR
    } jump_e;

endpackage

`default_nettype wire

// ==== shared_mem.sv ====
// single-port memory, priority loader > data > fetch; word index is addr[9:2], low bits ignored
`timescale 1ns/1ps
`default_nettype none

module shared_mem (
    input  logic       clk_i,
    mem_port_if.memory load_port,
    mem_port_if.memory data_port,
    mem_port_if.memory fetch_port
);
    import riscv_pkg::*;

    logic [XLEN-1:0]   mem_q [MEM_WORDS];
    logic              sel_we;
    logic [XLEN-1:0]   sel_addr;
    logic [XLEN-1:0]   sel_wdata;
    logic [MEM_AW-1:0] idx;
    logic [XLEN-1:0]   rd_word;

    assign load_port.gnt  = load_port.req;
    assign data_port.gnt  = data_port.req & ~load_port.req;
    assign fetch_port.gnt = fetch_port.req & ~load_port.req & ~data_port.req;

    always_comb
    begin
        if (load_port.req)
        begin
            sel_we    = load_port.we;
            sel_addr  = load_port.addr;
            sel_wdata = load_port.wdata;
        end
        else if (data_port.req)
        begin
            sel_we    = data_port.we;
            sel_addr  = data_port.addr;
            sel_wdata = data_port.wdata;
        end
        else
        begin
            sel_we    = fetch_port.gnt & fetch_port.we;
            sel_addr  = fetch_port.addr;
            sel_wdata = fetch_port.wdata;
        end
    end

    assign idx     = sel_addr[MEM_AW+1:2];
    assign rd_word = mem_q[idx];              // asynchronous read

    // every port sees the word at the granted address
    assign load_port.rdata  = rd_word;
    assign data_port.rdata  = rd_word;
    assign fetch_port.rdata = rd_word;

    always_ff @(posedge clk_i)
    begin
        if (sel_we)
            mem_q[idx] <= sel_wdata;
    end

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
// 20 ns clock from time zero; rst_o is high for the first 4 rising edges and then stays low
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk_o,
    output logic rst_o
);

    initial
    begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;      // 20 ns period
    end

    initial
    begin
        rst_o = 1'b1;
        repeat (4) @(posedge clk_o);
        rst_o <= 1'b0;                   // released right after the 4th edge
    end

endmodule

`default_nettype wire

// ==== tb_cpu.sv ====
// reads cpu_golden.hex from the project root; trace items must arrive in the order of the file
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;
    import riscv_pkg::*;

    localparam int MAX_ITEMS = 64;
    localparam int DRAIN     = 20;           // quiet cycles after the last item

    logic            clk;
    logic            rst;
    logic            load_we;
    logic [XLEN-1:0] load_addr;
    logic [XLEN-1:0] load_data;
    logic            wb_valid;
    logic [4:0]      wb_rd;
    logic [XLEN-1:0] wb_data;
    logic            st_valid;
    logic [XLEN-1:0] st_addr;
    logic [XLEN-1:0] st_data;

    logic [XLEN-1:0] prog_mem [MAX_ITEMS];
    logic [7:0]      exp_kind [MAX_ITEMS];   // "W" or "S"
    logic [XLEN-1:0] exp_a [MAX_ITEMS];      // rd or store address
    logic [XLEN-1:0] exp_b [MAX_ITEMS];
    int              n_prog;
    int              n_exp;
    int              next_item;
    int              cycles;
    int              limit;
    int              value_errors;
    int              other_errors;
    bit              golden_ok;

    tb_clk_gen u_clk (
        .clk_o(clk),
        .rst_o(rst)
    );

    cpu_top u_dut (
        .clk_i      (clk),
        .rst_i      (rst),
        .load_we_i  (load_we),
        .load_addr_i(load_addr),
        .load_data_i(load_data),
        .wb_valid_o (wb_valid),
        .wb_rd_o    (wb_rd),
        .wb_data_o  (wb_data),
        .st_valid_o (st_valid),
        .st_addr_o  (st_addr),
        .st_data_o  (st_data)
    );

    task automatic read_golden();
        int              fd;
        int              rc;
        int              n;
        string           line;
        logic [7:0]      tag;
        logic [XLEN-1:0] v1;
        logic [XLEN-1:0] v2;
        opcode_e         last_op;
        fd = $fopen("cpu_golden.hex", "r");
        if (fd == 0)
        begin
            $display("cannot open cpu_golden.hex");
            other_errors++;
            return;
        end
        while (!$feof(fd))
        begin
            line = "";
            rc = $fgets(line, fd);
            n = $sscanf(line, "%c %h %h", tag, v1, v2);
            if (rc == 0 || n < 1 || tag == "#" || tag == 8'h0a || tag == " ")
                continue;                    // comment or blank line
            if (tag == "P" && n >= 2)
            begin
                prog_mem[n_prog] = v1;
                n_prog++;
                if (v1 != '0)
                    last_op = opcode_e'(v1[6:0]);
            end
            else if ((tag == "W" || tag == "S") && n == 3)
            begin
                exp_kind[n_exp] = tag;
                exp_a[n_exp]    = v1;
                exp_b[n_exp]    = v2;
                n_exp++;
            end
            else
            begin
                $display("golden file line not understood: %0s", line);
                other_errors++;
            end
        end
        $fclose(fd);
        golden_ok = (n_prog > 0 && n_exp > 0);
        if (!golden_ok)
            $display("golden file holds no program or no expected trace");
        else if (last_op != JAL)
        begin
            $display("program does not end in a jal self-loop");
            other_errors++;
        end
    endtask

    task automatic check_trace();
        if (wb_valid)
        begin
            assert (next_item < n_exp && exp_kind[next_item] == "W")
            begin
                assert (wb_rd == exp_a[next_item][4:0])
                else
                begin
                    $display("FAIL wb_rd_o item %0d expected %h got %h",
                             next_item, exp_a[next_item][4:0], wb_rd);
                    value_errors++;
                end
                assert (wb_data == exp_b[next_item])
                else
                begin
                    $display("FAIL wb_data_o item %0d expected %h got %h",
                             next_item, exp_b[next_item], wb_data);
                    value_errors++;
                end
                next_item++;
            end
            else
            begin
                $display("register write to x%0d of %h was not expected here", wb_rd, wb_data);
                other_errors++;
            end
        end
        if (st_valid)
        begin
            assert (next_item < n_exp && exp_kind[next_item] == "S")
            begin
                assert (st_addr == exp_a[next_item])
                else
                begin
                    $display("FAIL st_addr_o item %0d expected %h got %h",
                             next_item, exp_a[next_item], st_addr);
                    value_errors++;
                end
                assert (st_data == exp_b[next_item])
                else
                begin
                    $display("FAIL st_data_o item %0d expected %h got %h",
                             next_item, exp_b[next_item], st_data);
                    value_errors++;
                end
                next_item++;
            end
            else
            begin
                $display("store of %h to %h was not expected here", st_data, st_addr);
                other_errors++;
            end
        end
    endtask

    // outputs change on the rising edge, so the falling edge is a safe place to look
    task automatic step_cycle();
        @(negedge clk);
        cycles++;
        check_trace();
    endtask

    initial
    begin
        load_we   = 1'b0;
        load_addr = '0;
        load_data = '0;
        read_golden();
        limit = (n_prog + n_exp) * 8 + n_prog + 20;
        if (golden_ok)
        begin
            wait (rst === 1'b0);
            @(negedge clk);
            for (int i = 0; i < n_prog; i++)
            begin
                load_we   = 1'b1;
                load_addr = XLEN'(i * 4);
                load_data = prog_mem[i];
                step_cycle();
            end
            load_we   = 1'b0;                // core starts fetching from address zero
            load_addr = '0;
            load_data = '0;
            while (next_item < n_exp && cycles < limit)
                step_cycle();
            assert (next_item == n_exp)
            else
            begin
                $display("timeout after %0d cycles, only %0d of %0d trace items seen",
                         cycles, next_item, n_exp);
                other_errors++;
            end
            if (next_item == n_exp)
                repeat (DRAIN) step_cycle(); // the self-loop must stay silent
        end
        else
            other_errors++;
        $display("trace %0d of %0d, value errors %0d, other errors %0d, assertion failures %0d",
                 next_item, n_exp, value_errors, other_errors, u_dut.u_props.fire_count);
        if (value_errors == 0 && other_errors == 0 && u_dut.u_props.fire_count == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
riscv_pkg.sv
mem_port_if.sv
reg_file.sv
fetch_stage.sv
decoder.sv
pipe_reg2.sv
execute_stage.sv
shared_mem.sv
cpu_top.sv
tb_clk_gen.sv
cpu_assertions.sv
tb_cpu.sv
